//--- src/chebPkg.sv
`default_nettype none

package chebPkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////
	localparam int NUM_COEFF = 6;
	localparam int WORD_W = 16;
	localparam int LONG_W = 32;
	localparam int IDX_W = 3;
	localparam int CNT_W = 5;

	// highest order the recursion runs to, f[1] .. f[5]
	localparam logic [IDX_W-1:0] MAX_ORDER = 3'd5;

	////////////////////////////////////////
	// recursion constants
	////////////////////////////////////////
	localparam logic [WORD_W-1:0] MAC_SCALE_C = 16'd4096;
	localparam logic [WORD_W-1:0] MAC_SCALE_LAST = 16'd2048;
	localparam logic [WORD_W-1:0] X_SCALE = 16'd512;
	localparam logic [WORD_W-1:0] B2_INIT = 16'd256;
	localparam logic [CNT_W-1:0] SHL_FINAL = 5'd6;

	// saturation limits
	localparam logic [WORD_W-1:0] MAX_WORD = 16'h7fff;
	localparam logic [WORD_W-1:0] MIN_WORD = 16'h8000;
	localparam logic [LONG_W-1:0] MAX_LONG = 32'h7fff_ffff;
	localparam logic [LONG_W-1:0] MIN_LONG = 32'h8000_0000;

	typedef struct packed {
		logic we;
		logic bank;
		logic [IDX_W-1:0] idx;
		logic [WORD_W-1:0] data;
	} coeffWrite_t;

	typedef struct packed {
		logic bank;
		logic [WORD_W-1:0] x;
		logic [IDX_W-1:0] order;
	} evalReq_t;

	// c + / - 2*a*b
	typedef struct packed {
		logic [WORD_W-1:0] a;
		logic [WORD_W-1:0] b;
		logic [LONG_W-1:0] c;
	} macOp_t;

	typedef struct packed {
		logic [LONG_W-1:0] value;
		logic [CNT_W-1:0] count;
	} shlReq_t;

endpackage

`default_nettype wire

//--- src/coeffBank.sv
`timescale 1ns/1ps
`default_nettype none

module coeffBank
(
	input wire clk,
	input wire reset,
	input wire chebPkg::coeffWrite_t wr,
	input wire rdBank,
	input wire [chebPkg::IDX_W-1:0] rdIdx,
	output logic [chebPkg::WORD_W-1:0] rdData
);

	// bank 0 holds F1, bank 1 holds F2
	logic [chebPkg::WORD_W-1:0] coeff [2][chebPkg::NUM_COEFF];

	////////////////////////////////////////
	// write side
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int b = 0; b < 2; b++)
			begin
				for (int i = 0; i < chebPkg::NUM_COEFF; i++)
				begin
					coeff[b][i] <= '0;
				end
			end
		end
		else if (wr.we)
		begin
			for (int b = 0; b < 2; b++)
			begin
				for (int i = 0; i < chebPkg::NUM_COEFF; i++)
				begin
					// indices 6 and 7 match nothing and are dropped
					if (wr.bank == 1'(b) && wr.idx == 3'(i))
						coeff[b][i] <= wr.data;
				end
			end
		end
	end

	////////////////////////////////////////
	// read side
	////////////////////////////////////////
	// six-way select within the chosen bank, zero past the end
	always_comb
	begin
		rdData = '0;
		for (int i = 0; i < chebPkg::NUM_COEFF; i++)
		begin
			if (rdIdx == 3'(i))
				rdData = coeff[rdBank][i];
		end
	end

endmodule

`default_nettype wire

//--- src/fracMulAcc.sv
`timescale 1ns/1ps
`default_nettype none

module fracMulAcc
(
	input wire [chebPkg::WORD_W-1:0] multA,
	input wire [chebPkg::WORD_W-1:0] multB,
	output logic [chebPkg::LONG_W-1:0] multOut,
	input wire chebPkg::macOp_t mac,
	output logic [chebPkg::LONG_W-1:0] macOut,
	input wire chebPkg::macOp_t msu,
	output logic [chebPkg::LONG_W-1:0] msuOut,
	input wire [chebPkg::WORD_W-1:0] fmA,
	input wire [chebPkg::WORD_W-1:0] fmB,
	output logic [chebPkg::WORD_W-1:0] fmOut,
	input wire [chebPkg::LONG_W-1:0] shrIn,
	output logic [chebPkg::WORD_W-1:0] shrOut
);

	////////////////////////////////////////
	// basic operations
	////////////////////////////////////////
	// L_mult: 2*a*b, only -32768 * -32768 overflows
	function automatic logic [chebPkg::LONG_W-1:0] lMult(
		input logic [chebPkg::WORD_W-1:0] a,
		input logic [chebPkg::WORD_W-1:0] b);
		logic signed [chebPkg::LONG_W-1:0] prod;
		prod = 32'($signed(a)) * 32'($signed(b));
		if (prod == 32'sh4000_0000)
			return chebPkg::MAX_LONG;
		return {prod[30:0], 1'b0};
	endfunction

	// L_add with saturation on same-sign overflow
	function automatic logic [chebPkg::LONG_W-1:0] lAdd(
		input logic [chebPkg::LONG_W-1:0] x,
		input logic [chebPkg::LONG_W-1:0] y);
		logic [chebPkg::LONG_W-1:0] sum;
		sum = x + y;
		if (x[31] == y[31] && sum[31] != x[31])
			return x[31] ? chebPkg::MIN_LONG : chebPkg::MAX_LONG;
		return sum;
	endfunction

	// L_sub, overflow only when the signs differ
	function automatic logic [chebPkg::LONG_W-1:0] lSub(
		input logic [chebPkg::LONG_W-1:0] x,
		input logic [chebPkg::LONG_W-1:0] y);
		logic [chebPkg::LONG_W-1:0] diff;
		diff = x - y;
		if (x[31] != y[31] && diff[31] != x[31])
			return x[31] ? chebPkg::MIN_LONG : chebPkg::MAX_LONG;
		return diff;
	endfunction

	assign multOut = lMult(multA, multB);
	assign macOut = lAdd(mac.c, lMult(mac.a, mac.b));
	assign msuOut = lSub(msu.c, lMult(msu.a, msu.b));

	// mult: truncate a*b to Q15, then clamp to a word
	logic signed [chebPkg::LONG_W-1:0] fmProd;
	logic signed [chebPkg::LONG_W-1:0] fmShift;

	always_comb
	begin
		fmProd = 32'($signed(fmA)) * 32'($signed(fmB));
		fmShift = fmProd >>> 15;
		if (fmShift > 32'sd32767)
			fmOut = chebPkg::MAX_WORD;
		else if (fmShift < -32'sd32768)
			fmOut = chebPkg::MIN_WORD;
		else
			fmOut = fmShift[15:0];
	end

	// low part of L_Extract, always 0 .. 32767
	assign shrOut = {1'b0, shrIn[15:1]};

endmodule

`default_nettype wire

//--- src/longShifter.sv
`timescale 1ns/1ps
`default_nettype none

module longShifter
(
	input wire clk,
	input wire reset,
	input wire ready,
	input wire chebPkg::shlReq_t req,
	output logic done,
	output logic [chebPkg::LONG_W-1:0] result
);

	typedef enum logic {
		S_IDLE,
		S_SHIFT
	} state_t;

	state_t state;
	logic [chebPkg::LONG_W-1:0] work;
	logic [chebPkg::CNT_W-1:0] remaining;
	logic overflow;

	// top two bits differ, so doubling would leave the long range
	assign overflow = work[31] != work[30];

	////////////////////////////////////////
	// control
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			remaining <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (ready)
					begin
						state <= S_SHIFT;
						remaining <= req.count;
					end
				end
				S_SHIFT:
				begin
					if (remaining == '0)
						state <= S_IDLE;
					else if (overflow)
						remaining <= '0;
					else
						remaining <= remaining - 5'd1;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// working value, one bit per cycle or forced to the extreme
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && ready)
			work <= req.value;
		else if (state == S_SHIFT && remaining != '0)
		begin
			if (overflow)
				work <= work[31] ? chebPkg::MIN_LONG : chebPkg::MAX_LONG;
			else
				work <= {work[30:0], 1'b0};
		end
	end

	assign done = (state == S_SHIFT) && (remaining == '0);
	assign result = work;

endmodule

`default_nettype wire

//--- src/chebEval.sv
`timescale 1ns/1ps
`default_nettype none

module chebEval
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire chebPkg::evalReq_t req,
	output logic [chebPkg::IDX_W-1:0] coeffIdx,
	output logic coeffBank,
	input wire [chebPkg::WORD_W-1:0] coeffIn,
	output logic [chebPkg::WORD_W-1:0] multA,
	output logic [chebPkg::WORD_W-1:0] multB,
	input wire [chebPkg::LONG_W-1:0] multOut,
	output chebPkg::macOp_t mac,
	input wire [chebPkg::LONG_W-1:0] macOut,
	output chebPkg::macOp_t msu,
	input wire [chebPkg::LONG_W-1:0] msuOut,
	output logic [chebPkg::WORD_W-1:0] fmA,
	output logic [chebPkg::WORD_W-1:0] fmB,
	input wire [chebPkg::WORD_W-1:0] fmOut,
	output logic [chebPkg::LONG_W-1:0] shrIn,
	input wire [chebPkg::WORD_W-1:0] shrOut,
	output logic shlReady,
	output chebPkg::shlReq_t shlReq,
	input wire shlDone,
	input wire [chebPkg::LONG_W-1:0] shlResult,
	output logic busy,
	output logic done,
	output logic [chebPkg::WORD_W-1:0] cheb
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_FIRST,
		S_LOOP_MPY,
		S_LOOP_SHL,
		S_LOOP_ACC,
		S_END_MPY,
		S_END_SUB,
		S_END_ACC,
		S_END_SHL,
		S_DONE
	} state_t;

	state_t state;
	state_t nextState;
	logic [chebPkg::IDX_W-1:0] count;
	logic [chebPkg::WORD_W-1:0] chebReg;

	// latched request
	logic [chebPkg::WORD_W-1:0] xReg;
	logic bankReg;
	logic [chebPkg::IDX_W-1:0] orderReg;

	// b1, b2 as hi/lo pairs and the running long
	logic [chebPkg::WORD_W-1:0] b1H;
	logic [chebPkg::WORD_W-1:0] b1L;
	logic [chebPkg::WORD_W-1:0] b2H;
	logic [chebPkg::WORD_W-1:0] b2L;
	logic [chebPkg::LONG_W-1:0] t0;

	////////////////////////////////////////
	// sequencing
	////////////////////////////////////////
	always_comb
	begin
		nextState = state;
		shlReady = 1'b0;
		shlReq = '0;
		case (state)
			S_IDLE:
				if (start)
					nextState = S_FIRST;
			S_FIRST:
				nextState = S_LOOP_MPY;
			S_LOOP_MPY:
				nextState = (count < orderReg) ? S_LOOP_SHL : S_END_MPY;
			S_LOOP_SHL:
			begin
				shlReq.value = t0;
				shlReq.count = 5'd1;
				shlReady = !shlDone;
				if (shlDone)
					nextState = S_LOOP_ACC;
			end
			S_LOOP_ACC:
				nextState = S_LOOP_MPY;
			S_END_MPY:
				nextState = S_END_SUB;
			S_END_SUB:
				nextState = S_END_ACC;
			S_END_ACC:
				nextState = S_END_SHL;
			S_END_SHL:
			begin
				shlReq.value = t0;
				shlReq.count = chebPkg::SHL_FINAL;
				shlReady = !shlDone;
				if (shlDone)
					nextState = S_DONE;
			end
			S_DONE:
				nextState = S_IDLE;
			default:
				nextState = S_IDLE;
		endcase
	end

	// f[1] for the first term, f[count] after that
	assign coeffIdx = (state == S_FIRST) ? 3'd1 : count;
	assign coeffBank = bankReg;

	////////////////////////////////////////
	// operand routing
	////////////////////////////////////////
	// products, including Mpy_32_16 of b1 by x
	always_comb
	begin
		multA = '0;
		multB = '0;
		fmA = '0;
		fmB = '0;
		case (state)
			S_FIRST:
			begin
				multA = xReg;
				multB = chebPkg::X_SCALE;
			end
			S_LOOP_MPY, S_END_MPY:
			begin
				multA = b1H;
				multB = xReg;
				fmA = b1L;
				fmB = xReg;
			end
			default:
			begin
			end
		endcase
	end

	always_comb
	begin
		mac = '0;
		case (state)
			S_FIRST:
			begin
				mac.a = coeffIn;
				mac.b = chebPkg::MAC_SCALE_C;
				mac.c = multOut;
			end
			S_LOOP_MPY, S_END_MPY:
			begin
				mac.a = fmOut;
				mac.b = 16'd1;
				mac.c = multOut;
			end
			S_LOOP_SHL:
			begin
				mac.a = b2H;
				mac.b = chebPkg::MIN_WORD;
				mac.c = shlResult;
			end
			S_LOOP_ACC:
			begin
				mac.a = coeffIn;
				mac.b = chebPkg::MAC_SCALE_C;
				mac.c = t0;
			end
			S_END_SUB:
			begin
				mac.a = b2H;
				mac.b = chebPkg::MIN_WORD;
				mac.c = t0;
			end
			S_END_ACC:
			begin
				mac.a = coeffIn;
				mac.b = chebPkg::MAC_SCALE_LAST;
				mac.c = t0;
			end
			default:
			begin
			end
		endcase
	end

	// subtract b2 low after adding -b2 high
	always_comb
	begin
		msu = '0;
		if (state == S_LOOP_SHL || state == S_END_SUB)
		begin
			msu.a = b2L;
			msu.b = 16'd1;
			msu.c = macOut;
		end
	end

	assign shrIn = macOut;

	////////////////////////////////////////
	// registers
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			count <= 3'd2;
			chebReg <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == S_FIRST)
				count <= 3'd2;
			else if (state == S_LOOP_ACC)
				count <= count + 3'd1;
			if (state == S_END_SHL && shlDone)
				chebReg <= shlResult[31:16];
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
			S_IDLE:
			begin
				if (start)
				begin
					xReg <= req.x;
					bankReg <= req.bank;
					orderReg <= (req.order > chebPkg::MAX_ORDER) ? chebPkg::MAX_ORDER : req.order;
				end
			end
			S_FIRST:
			begin
				b1H <= macOut[31:16];
				b1L <= shrOut;
				b2H <= chebPkg::B2_INIT;
				b2L <= '0;
			end
			S_LOOP_MPY, S_END_MPY, S_END_ACC:
				t0 <= macOut;
			S_LOOP_SHL:
				if (shlDone)
					t0 <= msuOut;
			S_END_SUB:
				t0 <= msuOut;
			S_LOOP_ACC:
			begin
				b2H <= b1H;
				b2L <= b1L;
				b1H <= macOut[31:16];
				b1L <= shrOut;
			end
			default:
			begin
			end
		endcase
	end

	assign busy = state != S_IDLE;
	assign done = state == S_DONE;
	assign cheb = chebReg;

endmodule

`default_nettype wire

//--- src/chebTop.sv
`timescale 1ns/1ps
`default_nettype none

module chebTop
(
	input wire clk,
	input wire reset,
	input wire chebPkg::coeffWrite_t coeffWr,
	input wire start,
	input wire chebPkg::evalReq_t req,
	output logic busy,
	output logic done,
	output logic [chebPkg::WORD_W-1:0] cheb
);

	logic [chebPkg::IDX_W-1:0] coeffIdx;
	logic rdBank;
	logic [chebPkg::WORD_W-1:0] coeffWord;

	// arithmetic unit requests and results
	logic [chebPkg::WORD_W-1:0] multA;
	logic [chebPkg::WORD_W-1:0] multB;
	logic [chebPkg::LONG_W-1:0] multOut;
	chebPkg::macOp_t mac;
	logic [chebPkg::LONG_W-1:0] macOut;
	chebPkg::macOp_t msu;
	logic [chebPkg::LONG_W-1:0] msuOut;
	logic [chebPkg::WORD_W-1:0] fmA;
	logic [chebPkg::WORD_W-1:0] fmB;
	logic [chebPkg::WORD_W-1:0] fmOut;
	logic [chebPkg::LONG_W-1:0] shrIn;
	logic [chebPkg::WORD_W-1:0] shrOut;

	// shifter handshake
	logic shlReady;
	chebPkg::shlReq_t shlReq;
	logic shlDone;
	logic [chebPkg::LONG_W-1:0] shlResult;

	coeffBank bank (.clk(clk), .reset(reset), .wr(coeffWr), .rdBank(rdBank),
		.rdIdx(coeffIdx), .rdData(coeffWord));

	chebEval evaluator (.clk(clk), .reset(reset), .start(start), .req(req),
		.coeffIdx(coeffIdx), .coeffBank(rdBank), .coeffIn(coeffWord),
		.multA(multA), .multB(multB), .multOut(multOut), .mac(mac), .macOut(macOut),
		.msu(msu), .msuOut(msuOut), .fmA(fmA), .fmB(fmB), .fmOut(fmOut),
		.shrIn(shrIn), .shrOut(shrOut), .shlReady(shlReady), .shlReq(shlReq),
		.shlDone(shlDone), .shlResult(shlResult), .busy(busy), .done(done), .cheb(cheb));

	fracMulAcc mathUnit (.multA(multA), .multB(multB), .multOut(multOut),
		.mac(mac), .macOut(macOut), .msu(msu), .msuOut(msuOut),
		.fmA(fmA), .fmB(fmB), .fmOut(fmOut), .shrIn(shrIn), .shrOut(shrOut));

	longShifter shifter (.clk(clk), .reset(reset), .ready(shlReady), .req(shlReq),
		.done(shlDone), .result(shlResult));

endmodule

`default_nettype wire

//--- include/chebRefModel.svh
`ifndef CHEB_REF_MODEL_SVH
`define CHEB_REF_MODEL_SVH

////////////////////////////////////////
// G.729 basic operations, 2-state
////////////////////////////////////////
function automatic int refSat32(input longint v);
	if (v > 64'sd2147483647)
		return 32'sh7fff_ffff;
	if (v < -64'sd2147483648)
		return 32'sh8000_0000;
	return int'(v);
endfunction

function automatic int refLMult(input shortint a, input shortint b);
	int prod;
	prod = int'(a) * int'(b);
	if (prod == 32'sh4000_0000)
		return 32'sh7fff_ffff;
	return prod * 2;
endfunction

function automatic int refLMac(input int acc, input shortint a, input shortint b);
	return refSat32(longint'(acc) + longint'(refLMult(a, b)));
endfunction

function automatic int refLMsu(input int acc, input shortint a, input shortint b);
	return refSat32(longint'(acc) - longint'(refLMult(a, b)));
endfunction

function automatic shortint refMult(input shortint a, input shortint b);
	int prod;
	prod = (int'(a) * int'(b)) >>> 15;
	if (prod > 32767)
		return 16'sh7fff;
	if (prod < -32768)
		return 16'sh8000;
	return shortint'(prod);
endfunction

function automatic int refLShl(input int v, input int n);
	for (int k = 0; k < n; k++)
	begin
		if (v > 32'sh3fff_ffff)
			return 32'sh7fff_ffff;
		if (v < 32'shc000_0000)
			return 32'sh8000_0000;
		v = v * 2;
	end
	return v;
endfunction

// L_Extract low part, the C way
function automatic shortint refExtractL(input int t0);
	return shortint'(refLMsu(t0 >>> 1, shortint'(t0 >>> 16), 16384));
endfunction

////////////////////////////////////////
// Chebps_11
////////////////////////////////////////
function automatic shortint refCheb(input shortint x,
	input shortint f [chebPkg::NUM_COEFF], input int n);
	shortint b0H;
	shortint b0L;
	shortint b1H;
	shortint b1L;
	shortint b2H;
	shortint b2L;
	int t0;
	int i;
	int last;
	last = (n > int'(chebPkg::MAX_ORDER)) ? int'(chebPkg::MAX_ORDER) : n;
	b2H = 256;
	b2L = 0;
	t0 = refLMult(x, 512);
	t0 = refLMac(t0, f[1], 4096);
	b1H = shortint'(t0 >>> 16);
	b1L = refExtractL(t0);
	for (i = 2; i < last; i++)
	begin
		t0 = refLMac(refLMult(b1H, x), refMult(b1L, x), 1);
		t0 = refLShl(t0, 1);
		t0 = refLMac(t0, b2H, 16'sh8000);
		t0 = refLMsu(t0, b2L, 1);
		t0 = refLMac(t0, f[i], 4096);
		b0H = shortint'(t0 >>> 16);
		b0L = refExtractL(t0);
		b2H = b1H;
		b2L = b1L;
		b1H = b0H;
		b1L = b0L;
	end
	// closing terms, f[i] with i where the loop stopped
	t0 = refLMac(refLMult(b1H, x), refMult(b1L, x), 1);
	t0 = refLMac(t0, b2H, 16'sh8000);
	t0 = refLMsu(t0, b2L, 1);
	t0 = refLMac(t0, f[i], 2048);
	t0 = refLShl(t0, 6);
	return shortint'(t0 >>> 16);
endfunction

`endif

//--- dv/chebTb.sv
`timescale 1ns/1ps
`default_nettype none

module chebTb;

	localparam int DONE_TIMEOUT = 200;
	localparam int QUIET_CYCLES = 60;
	localparam int RANDOM_ROWS = 24;

	// coefficient sets, f[0] .. f[5]
	localparam logic [0:5][15:0] LSP_F1 = {16'h0800, 16'hf310, 16'h0f80, 16'hf200, 16'h0a00,
		16'hfc10};
	localparam logic [0:5][15:0] LSP_F2 = {16'h0800, 16'h05de, 16'h0b18, 16'h07c0, 16'h085e,
		16'h01f0};
	localparam logic [0:5][15:0] FULL_POS = {6{16'h7fff}};
	localparam logic [0:5][15:0] FULL_NEG = {6{16'h8000}};
	localparam logic [0:5][15:0] MIXED = {3{16'h7fff, 16'h8000}};
	localparam logic [0:5][15:0] ZEROS = {6{16'h0000}};

	typedef struct packed {
		logic bank;
		logic [2:0] order;
		logic [15:0] x;
		logic [0:5][15:0] coeff;
		logic fromModel;
		logic [15:0] expected;
	} testRow_t;

	logic clk;
	logic reset;
	logic start;
	chebPkg::coeffWrite_t coeffWr;
	chebPkg::evalReq_t req;
	logic busy;
	logic done;
	logic [15:0] cheb;

	testRow_t rows[$];
	int errors;
	int checks;
	int seed;

	`include "chebRefModel.svh"

	chebTop dut (.clk(clk), .reset(reset), .coeffWr(coeffWr), .start(start), .req(req),
		.busy(busy), .done(done), .cheb(cheb));

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		checks++;
		if (got !== expected)
		begin
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, expected);
			errors++;
		end
	endtask

	function automatic testRow_t makeRow(input logic bank, input logic [2:0] order,
		input logic [15:0] x, input logic [0:5][15:0] c, input logic fromModel,
		input logic [15:0] expected);
		testRow_t row;
		row.bank = bank;
		row.order = order;
		row.x = x;
		row.coeff = c;
		row.fromModel = fromModel;
		row.expected = expected;
		return row;
	endfunction

	function automatic logic [15:0] expectedFor(input testRow_t row);
		shortint f [chebPkg::NUM_COEFF];
		if (!row.fromModel)
			return row.expected;
		for (int i = 0; i < chebPkg::NUM_COEFF; i++)
			f[i] = shortint'(row.coeff[i]);
		return refCheb(shortint'(row.x), f, int'(row.order));
	endfunction

	task automatic applyReset();
		@(negedge clk);
		reset = 1'b1;
		start = 1'b0;
		coeffWr = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic checkIdle(input string what);
		checkValue(busy, 0, {"busy ", what});
		checkValue(done, 0, {"done ", what});
		checkValue(cheb, 0, {"cheb ", what});
	endtask

	task automatic writeCoeffs(input logic bank, input logic [0:5][15:0] c);
		for (int i = 0; i < chebPkg::NUM_COEFF; i++)
		begin
			@(negedge clk);
			coeffWr.we = 1'b1;
			coeffWr.bank = bank;
			coeffWr.idx = 3'(i);
			coeffWr.data = c[i];
		end
		@(negedge clk);
		coeffWr = '0;
	endtask

	task automatic startEval(input testRow_t row);
		@(negedge clk);
		start = 1'b1;
		req.bank = row.bank;
		req.x = row.x;
		req.order = row.order;
		@(negedge clk);
		start = 1'b0;
	endtask

	// leaves the caller on the falling edge of the done cycle
	task automatic waitDone(output logic [15:0] result);
		int cycles;
		cycles = 0;
		result = '0;
		while (!done && cycles < DONE_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (done)
			result = cheb;
		else
		begin
			$display("timeout: done did not arrive within %0d cycles", DONE_TIMEOUT);
			errors++;
		end
	endtask

	task automatic runRow(input testRow_t row, input logic load, input string what);
		logic [15:0] result;
		if (load)
			writeCoeffs(row.bank, row.coeff);
		startEval(row);
		waitDone(result);
		checkValue(result, expectedFor(row), what);
	endtask

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////
	task automatic buildTable();
		// typical coefficients, order 5, both banks
		rows.push_back(makeRow(1'b0, 3'd5, 16'h7d00, LSP_F1, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b0, 3'd5, 16'h4000, LSP_F1, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b0, 3'd5, 16'hc000, LSP_F1, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b1, 3'd5, 16'h2100, LSP_F2, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b1, 3'd5, 16'h0000, LSP_F2, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b1, 3'd5, 16'h86e8, LSP_F2, 1'b1, 16'h0000));
		// loop count follows the order
		rows.push_back(makeRow(1'b0, 3'd2, 16'h2ee0, LSP_F1, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b0, 3'd3, 16'h2ee0, LSP_F1, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b0, 3'd4, 16'h2ee0, LSP_F1, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b1, 3'd3, 16'hdcd8, LSP_F2, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b1, 3'd7, 16'hdcd8, LSP_F2, 1'b1, 16'h0000));
		// x = 0 with cleared coefficients, worked out by hand
		rows.push_back(makeRow(1'b0, 3'd2, 16'h0000, ZEROS, 1'b0, 16'hc000));
		rows.push_back(makeRow(1'b0, 3'd4, 16'h0000, ZEROS, 1'b0, 16'h4000));
		rows.push_back(makeRow(1'b1, 3'd5, 16'h0000, ZEROS, 1'b0, 16'h0000));
		// full scale inputs and a saturating final shift
		rows.push_back(makeRow(1'b0, 3'd5, 16'h7fff, FULL_POS, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b1, 3'd5, 16'h8000, FULL_NEG, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b0, 3'd3, 16'h7fff, MIXED, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b1, 3'd5, 16'h8000, MIXED, 1'b1, 16'h0000));
		rows.push_back(makeRow(1'b0, 3'd2, 16'h8000, FULL_POS, 1'b1, 16'h0000));
	endtask

	////////////////////////////////////////
	// directed scenarios
	////////////////////////////////////////
	task automatic ignoredStart();
		testRow_t first;
		testRow_t second;
		logic [15:0] result;
		int extra;
		first = makeRow(1'b0, 3'd5, 16'h4e20, LSP_F1, 1'b1, 16'h0000);
		second = makeRow(1'b1, 3'd2, 16'hec78, LSP_F2, 1'b1, 16'h0000);
		writeCoeffs(1'b0, LSP_F1);
		writeCoeffs(1'b1, LSP_F2);
		startEval(first);
		checkValue(busy, 1, "busy after start");
		// second request while the first one runs
		@(negedge clk);
		start = 1'b1;
		req.bank = second.bank;
		req.x = second.x;
		req.order = second.order;
		repeat (3) @(negedge clk);
		start = 1'b0;
		waitDone(result);
		checkValue(result, expectedFor(first), "result with start raised while busy");
		extra = 0;
		repeat (QUIET_CYCLES)
		begin
			@(negedge clk);
			if (done)
				extra++;
		end
		checkValue(extra, 0, "done pulses after the first one");
		checkValue(busy, 0, "busy after the ignored start");
	endtask

	task automatic resetAndReload();
		testRow_t rowA;
		rowA = makeRow(1'b0, 3'd5, 16'h2a00, LSP_F1, 1'b1, 16'h0000);
		applyReset();
		checkIdle("after second reset");
		// reset clears the coefficients
		runRow(makeRow(1'b0, 3'd5, 16'h2a00, ZEROS, 1'b1, 16'h0000), 1'b0,
			"bank 0 cleared by reset");
		runRow(rowA, 1'b1, "bank 0 reloaded");
		writeCoeffs(1'b1, FULL_NEG);
		runRow(rowA, 1'b0, "bank 0 after rewriting bank 1");
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial
	begin
		testRow_t row;
		logic [0:5][15:0] c;
		reset = 1'b1;
		start = 1'b0;
		coeffWr = '0;
		req = '0;
		errors = 0;
		checks = 0;
		seed = 32'hb021_3bc6;

		applyReset();
		@(negedge clk);
		checkIdle("after reset");

		buildTable();
		foreach (rows[n])
			runRow(rows[n], 1'b1, $sformatf("table row %0d", n));

		for (int n = 0; n < RANDOM_ROWS; n++)
		begin
			for (int i = 0; i < chebPkg::NUM_COEFF; i++)
				c[i] = 16'($random(seed));
			row = makeRow(1'($random(seed)), 3'($random(seed)), 16'($random(seed)), c,
				1'b1, 16'h0000);
			runRow(row, 1'b1, $sformatf("random row %0d", n));
		end

		ignoredStart();
		resetAndReload();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
src/chebPkg.sv
src/coeffBank.sv
src/fracMulAcc.sv
src/longShifter.sv
src/chebEval.sv
src/chebTop.sv
dv/chebTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module chebTb -f list.f -o chebSim
./obj_dir/chebSim | tee run.log

if grep -q "RESULT: PASS" run.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
